/* capi_consts.svh */
`ifndef CAPI_CONSTS_SVH
`define CAPI_CONSTS_SVH

// Register space word addresses, doubleword aligned
`define ALGO_REQUEST 24'h00_0010
`define ALGO_STATUS  24'h00_0012
`define ERROR_REG    24'h00_0014

// AFU descriptor contents
// Dedicated process programming model
`define DESC_PROG_MODEL 16'h8010
// Interrupts per process, process count, config record count, model
`define DESC_WORD0      {16'h0000, 16'h0001, 16'h0001, `DESC_PROG_MODEL}
`define DESC_CR_LEN     56'h00_0000_0000_0001
`define DESC_CR_OFFSET  64'h0000_0000_0000_0100

// Fields of the algorithm request register, bit 0 is the MSB
`define ALGO_START_BIT 0
`define ALGO_COUNT_LSB 32

// Request sampled to ack, in clock cycles
`define PIPE_DEPTH 5

`endif

/* capi_pkg.sv */
package capi_pkg;

  // Host MMIO request from the service layer
  typedef struct packed {
    logic        valid;
    logic        cfg;
    logic        read;
    logic        doubleword;
    logic [0:23] address;
    logic        address_parity;
    logic [0:63] data;
    logic        data_parity;
  } mmio_in_t;

  // Response back to the service layer
  typedef struct packed {
    logic        ack;
    logic [0:63] data;
    logic        data_parity;
  } mmio_out_t;

  // AFU descriptor, one field group per doubleword
  typedef struct packed {
    logic [0:15]  num_ints_per_process;
    logic [0:15]  num_of_processes;
    logic [0:15]  num_of_afu_crs;
    logic [0:15]  req_prog_model;
    // Words 1 to 3
    logic [0:191] reserved_1;
    logic [0:7]   reserved_2;
    logic [0:55]  afu_cr_len;
    logic [0:63]  afu_cr_offset;
    logic [0:5]   reserved_3;
    logic         psa_per_process_required;
    logic         psa_required;
    logic [0:55]  psa_length;
    logic [0:63]  psa_offset;
    // No error buffer, the table ends with its length word
    logic [0:7]   reserved_4;
    logic [0:55]  afu_eb_len;
  } afu_descriptor_t;

  localparam int unsigned desc_words = 9;

  // Algorithm status register layout
  typedef struct packed {
    logic        busy;
    logic        done;
    logic [0:29] reserved;
    logic [0:31] count;
  } algo_status_t;

  // Parity bit that makes the total count of ones odd
  function automatic logic odd_parity(logic [0:63] value);
    return ~(^value);
  endfunction

  // Doubleword lookup, zero past the end of the table
  function automatic logic [0:63] read_afu_descriptor(afu_descriptor_t desc,
                                                      logic [0:22] index);
    logic [0:desc_words-1][0:63] words;
    words = desc;
    if (index < 23'(desc_words)) begin
      return words[index[19:22]];
    end
    return '0;
  endfunction

endpackage

/* mmio.sv */
`timescale 1ns/1ps
`include "capi_consts.svh"

module mmio (
  input  logic                 clock,
  input  logic                 rstn,
  input  capi_pkg::mmio_in_t   mmio_in,
  output capi_pkg::mmio_out_t  mmio_out,
  input  logic [0:63]          algorithm_status,
  input  logic [0:63]          report_errors,
  output logic [0:63]          algorithm_requests,
  output logic                 report_errors_ack,
  output logic [0:1]           mmio_errors
);

  localparam logic [0:63] desc_word0 = `DESC_WORD0;

  capi_pkg::afu_descriptor_t afu_desc;

  // Stage 1, input latch
  capi_pkg::mmio_in_t req_s1;
  logic               valid_s1;
  logic               addr_par_calc;
  logic               data_par_calc;

  // Stage 2, decode
  logic               cfg_rd_s2;
  logic               cfg_wr_s2;
  logic               reg_rd_s2;
  logic               reg_wr_s2;
  logic               dw_s2;
  logic [0:23]        addr_s2;
  logic [0:63]        wdata_s2;
  logic [0:1]         err_s2;

  // Stage 3, second latch with descriptor lookup
  logic               cfg_rd_s3;
  logic               cfg_wr_s3;
  logic               reg_rd_s3;
  logic               reg_wr_s3;
  logic               dw_s3;
  logic [0:23]        addr_s3;
  logic [0:63]        wdata_s3;
  logic [0:63]        cfg_word_s3;
  logic [0:1]         err_s3;

  // Stage 4 and 5, data and output
  logic               ack_s4;
  logic [0:63]        data_out;
  logic [0:1]         err_s4;
  logic               ack_s5;
  logic [0:63]        rdata_s5;
  logic               rpar_s5;

  assign afu_desc.num_ints_per_process     = desc_word0[0:15];
  assign afu_desc.num_of_processes         = desc_word0[16:31];
  assign afu_desc.num_of_afu_crs           = desc_word0[32:47];
  assign afu_desc.req_prog_model           = desc_word0[48:63];
  assign afu_desc.reserved_1               = '0;
  assign afu_desc.reserved_2               = '0;
  assign afu_desc.afu_cr_len               = `DESC_CR_LEN;
  assign afu_desc.afu_cr_offset            = `DESC_CR_OFFSET;
  assign afu_desc.reserved_3               = '0;
  assign afu_desc.psa_per_process_required = 1'b0;
  assign afu_desc.psa_required             = 1'b1;
  assign afu_desc.psa_length               = '0;
  assign afu_desc.psa_offset               = '0;
  assign afu_desc.reserved_4               = '0;
  assign afu_desc.afu_eb_len               = '0;

////////////////////////////////////////////////////////////////////////////
// Input latch and decode
////////////////////////////////////////////////////////////////////////////

  always_ff @(posedge clock or negedge rstn) begin
    if (!rstn) begin
      valid_s1 <= 1'b0;
    end else begin
      valid_s1 <= mmio_in.valid;
    end
  end

  always_ff @(posedge clock) begin
    req_s1 <= mmio_in;
  end

  // Recomputed parity of what the host sent
  assign addr_par_calc = capi_pkg::odd_parity({40'd0, req_s1.address});
  assign data_par_calc = capi_pkg::odd_parity(req_s1.data);

  always_ff @(posedge clock or negedge rstn) begin
    if (!rstn) begin
      cfg_rd_s2 <= 1'b0;
      cfg_wr_s2 <= 1'b0;
      reg_rd_s2 <= 1'b0;
      reg_wr_s2 <= 1'b0;
      err_s2    <= 2'b00;
    end else begin
      cfg_rd_s2 <= valid_s1 &  req_s1.cfg &  req_s1.read;
      cfg_wr_s2 <= valid_s1 &  req_s1.cfg & ~req_s1.read;
      reg_rd_s2 <= valid_s1 & ~req_s1.cfg &  req_s1.read;
      reg_wr_s2 <= valid_s1 & ~req_s1.cfg & ~req_s1.read;
      // Data parity only counts on writes
      err_s2[0] <= valid_s1 & ~req_s1.read & (data_par_calc != req_s1.data_parity);
      err_s2[1] <= valid_s1 & (addr_par_calc != req_s1.address_parity);
    end
  end

  always_ff @(posedge clock) begin
    dw_s2    <= req_s1.doubleword;
    addr_s2  <= req_s1.address;
    wdata_s2 <= req_s1.data;
  end

  always_ff @(posedge clock or negedge rstn) begin
    if (!rstn) begin
      cfg_rd_s3 <= 1'b0;
      cfg_wr_s3 <= 1'b0;
      reg_rd_s3 <= 1'b0;
      reg_wr_s3 <= 1'b0;
      err_s3    <= 2'b00;
    end else begin
      cfg_rd_s3 <= cfg_rd_s2;
      cfg_wr_s3 <= cfg_wr_s2;
      reg_rd_s3 <= reg_rd_s2;
      reg_wr_s3 <= reg_wr_s2;
      err_s3    <= err_s2;
    end
  end

  always_ff @(posedge clock) begin
    dw_s3       <= dw_s2;
    addr_s3     <= addr_s2;
    wdata_s3    <= wdata_s2;
    cfg_word_s3 <= capi_pkg::read_afu_descriptor(afu_desc, addr_s2[0:22]);
  end

////////////////////////////////////////////////////////////////////////////
// Register access and read data
////////////////////////////////////////////////////////////////////////////

  always_ff @(posedge clock or negedge rstn) begin
    if (!rstn) begin
      ack_s4             <= 1'b0;
      err_s4             <= 2'b00;
      data_out           <= '0;
      algorithm_requests <= '0;
      report_errors_ack  <= 1'b0;
    end else begin
      ack_s4            <= cfg_rd_s3 | cfg_wr_s3 | reg_rd_s3 | reg_wr_s3;
      err_s4            <= err_s3;
      report_errors_ack <= 1'b0;
      if (reg_wr_s3 && addr_s3 == `ALGO_REQUEST) begin
        algorithm_requests <= wdata_s3;
      end
      if (cfg_rd_s3) begin
        // Word reads repeat the selected half
        if (dw_s3) begin
          data_out <= cfg_word_s3;
        end else if (addr_s3[23]) begin
          data_out <= {cfg_word_s3[32:63], cfg_word_s3[32:63]};
        end else begin
          data_out <= {cfg_word_s3[0:31], cfg_word_s3[0:31]};
        end
      end else if (reg_rd_s3) begin
        case (addr_s3)
          `ALGO_STATUS: data_out <= algorithm_status;
          `ERROR_REG: begin
            data_out          <= report_errors;
            report_errors_ack <= 1'b1;
          end
          default: data_out <= data_out;
        endcase
      end
    end
  end

  always_ff @(posedge clock or negedge rstn) begin
    if (!rstn) begin
      ack_s5      <= 1'b0;
      mmio_errors <= 2'b00;
    end else begin
      ack_s5      <= ack_s4;
      mmio_errors <= err_s4;
    end
  end

  always_ff @(posedge clock) begin
    rdata_s5 <= data_out;
    rpar_s5  <= capi_pkg::odd_parity(data_out);
  end

  assign mmio_out = '{ack: ack_s5, data: rdata_s5, data_parity: rpar_s5};

  // One ack per request, fixed latency
  a_ack_latency: assert property (@(posedge clock) disable iff (!rstn)
    mmio_out.ack == $past(mmio_in.valid, `PIPE_DEPTH));

  // Error clear strobe leads the ack of its read
  a_err_ack_order: assert property (@(posedge clock) disable iff (!rstn)
    report_errors_ack |=> mmio_out.ack);

endmodule

/* algo_control.sv */
`timescale 1ns/1ps
`include "capi_consts.svh"

module algo_control (
  input  logic        clock,
  input  logic        rstn,
  input  logic [0:63] algorithm_requests,
  input  logic [0:1]  mmio_errors,
  input  logic        report_errors_ack,
  output logic [0:63] algorithm_status,
  output logic [0:63] report_errors
);

  logic                   start_req;
  logic                   start_q;
  logic                   start_edge;
  logic [0:31]            job_count;
  logic [0:31]            remaining;
  logic [0:31]            completed;
  logic                   busy;
  logic                   done;
  logic                   data_error;
  logic                   address_error;
  capi_pkg::algo_status_t status;

  assign start_req  = algorithm_requests[`ALGO_START_BIT];
  assign job_count  = algorithm_requests[`ALGO_COUNT_LSB +: 32];
  assign start_edge = start_req & ~start_q;

  always_ff @(posedge clock or negedge rstn) begin
    if (!rstn) begin
      start_q <= 1'b0;
    end else begin
      start_q <= start_req;
    end
  end

////////////////////////////////////////////////////////////////////////////
// Counted job
////////////////////////////////////////////////////////////////////////////

  always_ff @(posedge clock or negedge rstn) begin
    if (!rstn) begin
      busy      <= 1'b0;
      done      <= 1'b0;
      remaining <= '0;
      completed <= '0;
    end else if (busy) begin
      if (remaining != '0) begin
        remaining <= remaining - 32'd1;
        completed <= completed + 32'd1;
      end
      // Last iteration, or an empty job
      if (remaining <= 32'd1) begin
        busy <= 1'b0;
        done <= 1'b1;
      end
    end else if (start_edge) begin
      busy      <= 1'b1;
      done      <= 1'b0;
      remaining <= job_count;
      completed <= '0;
    end
  end

  assign status = '{busy: busy, done: done, reserved: '0, count: completed};
  assign algorithm_status = status;

  // Sticky bits, a new error beats the clear
  always_ff @(posedge clock or negedge rstn) begin
    if (!rstn) begin
      data_error    <= 1'b0;
      address_error <= 1'b0;
    end else begin
      data_error    <= mmio_errors[0] | (data_error & ~report_errors_ack);
      address_error <= mmio_errors[1] | (address_error & ~report_errors_ack);
    end
  end

  assign report_errors = {62'd0, data_error, address_error};

  a_busy_done: assert property (@(posedge clock) disable iff (!rstn)
    !(busy && done));

endmodule

/* afu_top.sv */
`timescale 1ns/1ps

module afu_top (
  input  logic                clock,
  input  logic                rstn,
  input  capi_pkg::mmio_in_t  mmio_in,
  output capi_pkg::mmio_out_t mmio_out,
  output logic [0:1]          mmio_errors
);

  logic [0:63] algorithm_requests;
  logic [0:63] algorithm_status;
  logic [0:63] report_errors;
  logic        report_errors_ack;

  // Host facing MMIO decoder
  mmio mmio_i (
    .clock              (clock),
    .rstn               (rstn),
    .mmio_in            (mmio_in),
    .mmio_out           (mmio_out),
    .algorithm_status   (algorithm_status),
    .report_errors      (report_errors),
    .algorithm_requests (algorithm_requests),
    .report_errors_ack  (report_errors_ack),
    .mmio_errors        (mmio_errors)
  );

  // Job control and error collection
  algo_control algo_control_i (
    .clock              (clock),
    .rstn               (rstn),
    .algorithm_requests (algorithm_requests),
    .mmio_errors        (mmio_errors),
    .report_errors_ack  (report_errors_ack),
    .algorithm_status   (algorithm_status),
    .report_errors      (report_errors)
  );

endmodule

/* tb_clock_gen.sv */
`timescale 1ns/1ps

module tb_clock_gen #(
  parameter int period = 20
) (
  output logic clock,
  output logic rstn
);

  initial begin
    clock = 1'b0;
    forever #(period / 2) clock = ~clock;
  end

  // Reset held low for four rising edges
  initial begin
    rstn = 1'b0;
    repeat (4) @(posedge clock);
    rstn <= 1'b1;
  end

endmodule

/* tb_checker.sv */
`timescale 1ns/1ps
`include "capi_consts.svh"

module tb_checker #(
  parameter int period = 20
) (
  input logic                clock,
  input logic                rstn,
  input capi_pkg::mmio_out_t mmio_out,
  input logic [0:1]          mmio_errors
);

  // Expectations in request order
  string       name_q[$];
  logic [0:63] data_q[$];
  logic [0:1]  err_q[$];
  time         time_q[$];

  int          error_count = 0;
  string       name;
  logic [0:63] exp_data;
  logic [0:1]  exp_err;
  time         sent;

  function automatic logic parity_of(logic [0:63] value);
    logic p;
    p = 1'b1;
    for (int i = 0; i < 64; i++) begin
      p = p ^ value[i];
    end
    return p;
  endfunction

  task automatic push_expect(input string n, input logic [0:63] d, input logic [0:1] e);
    name_q.push_back(n);
    data_q.push_back(d);
    err_q.push_back(e);
    time_q.push_back($time);
  endtask

  function automatic int pending_count();
    return name_q.size();
  endfunction

////////////////////////////////////////////////////////////////////////////
// Response compare on every ack
////////////////////////////////////////////////////////////////////////////

  always @(posedge clock) begin
    if (rstn && mmio_out.ack) begin
      if (name_q.size() == 0) begin
        $display("** Error: an ack arrived with no request pending at %0t", $time);
        error_count++;
      end else begin
        name     = name_q.pop_front();
        exp_data = data_q.pop_front();
        exp_err  = err_q.pop_front();
        sent     = time_q.pop_front();
        if (mmio_out.data !== exp_data) begin
          $display("** Error %s: data expected %h actual %h", name, exp_data, mmio_out.data);
          error_count++;
        end
        if (mmio_out.data_parity !== parity_of(exp_data)) begin
          $display("** Error %s: data_parity expected %b actual %b", name,
                   parity_of(exp_data), mmio_out.data_parity);
          error_count++;
        end
        if (mmio_errors !== exp_err) begin
          $display("** Error %s: mmio_errors expected %b actual %b", name, exp_err,
                   mmio_errors);
          error_count++;
        end
        // Timed from the drive edge one cycle ahead of the sampling edge
        if ($time - sent != time'(period * (`PIPE_DEPTH + 1))) begin
          $display("** Error %s: ack delay expected %0d ns actual %0d ns", name,
                   period * (`PIPE_DEPTH + 1), $time - sent);
          error_count++;
        end
      end
    end else if (rstn && mmio_errors != 2'b00) begin
      $display("** Error: mmio_errors went high outside an ack cycle at %0t", $time);
      error_count++;
    end
  end

endmodule

/* tb_top.sv */
`timescale 1ns/1ps
`include "capi_consts.svh"

module tb_top;

  localparam int clock_period = 20;
  localparam int job_len = 20;

  // One table row, request fields and expectation
  typedef struct packed {
    logic        cfg;
    logic        read;
    logic        dw;
    logic [0:23] addr;
    logic [0:63] data;
    logic        bad_dp;
    logic        bad_ap;
    logic        keep;
    logic [0:63] exp_data;
    logic [7:0]  gap;
  } stim_t;

  logic                clock;
  logic                rstn;
  capi_pkg::mmio_in_t  mmio_in;
  capi_pkg::mmio_out_t mmio_out;
  logic [0:1]          mmio_errors;

  stim_t       table_q[$];
  string       name_q[$];
  logic [31:0] lcg_state;
  int          table_len = 0;

  tb_clock_gen #(.period(clock_period)) clock_gen_i (.clock(clock), .rstn(rstn));

  afu_top dut_i (
    .clock       (clock),
    .rstn        (rstn),
    .mmio_in     (mmio_in),
    .mmio_out    (mmio_out),
    .mmio_errors (mmio_errors)
  );

  tb_checker #(.period(clock_period)) checker_i (
    .clock       (clock),
    .rstn        (rstn),
    .mmio_out    (mmio_out),
    .mmio_errors (mmio_errors)
  );

  function automatic logic odd_parity_of(logic [0:63] value);
    logic p;
    p = 1'b1;
    for (int i = 0; i < 64; i++) begin
      p = p ^ value[i];
    end
    return p;
  endfunction

  function automatic logic [0:63] draw_payload();
    logic [0:63] v;
    lcg_state = lcg_state * 32'd1664525 + 32'd1013904223;
    v[0:31] = lcg_state;
    lcg_state = lcg_state * 32'd1664525 + 32'd1013904223;
    v[32:63] = lcg_state;
    return v;
  endfunction

////////////////////////////////////////////////////////////////////////////
// Table building
////////////////////////////////////////////////////////////////////////////

  task automatic cfg_read(input string n, input logic [0:23] a, input logic dw,
                          input logic [0:63] exp);
    name_q.push_back(n);
    table_q.push_back('{cfg: 1'b1, read: 1'b1, dw: dw, addr: a, data: '0, bad_dp: 1'b0,
                        bad_ap: 1'b0, keep: 1'b0, exp_data: exp, gap: 8'd0});
  endtask

  task automatic reg_read(input string n, input logic [0:23] a, input logic keep,
                          input logic [0:63] exp, input logic bad_ap, input int gap);
    name_q.push_back(n);
    table_q.push_back('{cfg: 1'b0, read: 1'b1, dw: 1'b1, addr: a, data: '0, bad_dp: 1'b0,
                        bad_ap: bad_ap, keep: keep, exp_data: exp, gap: 8'(gap)});
  endtask

  // Write acks repeat the last read data
  task automatic reg_write(input string n, input logic [0:23] a, input logic [0:63] d,
                           input logic bad_dp, input int gap);
    name_q.push_back(n);
    table_q.push_back('{cfg: 1'b0, read: 1'b0, dw: 1'b1, addr: a, data: d, bad_dp: bad_dp,
                        bad_ap: 1'b0, keep: 1'b1, exp_data: '0, gap: 8'(gap)});
  endtask

  task automatic finish_run(input int errors);
    $display("Closing: %0d errors counted", errors);
    if (errors == 0) begin
      $display("Regression passed");
    end else begin
      $display("Regression failed");
    end
    $finish;
  endtask

  initial begin
    stim_t                  s;
    logic [0:63]            w0;
    logic [0:63]            exp;
    logic [0:63]            last_data;
    logic [0:63]            err_word;
    logic [0:63]            req;
    capi_pkg::algo_status_t st;
    mmio_in   = '0;
    lcg_state = 32'h00e7_8f5c;
    last_data = '0;
    w0        = `DESC_WORD0;

    cfg_read("desc_word0_dw", 24'h00_0000, 1'b1, w0);
    cfg_read("desc_word4_dw", {23'd4, 1'b0}, 1'b1, {8'h00, `DESC_CR_LEN});
    cfg_read("desc_word5_dw", {23'd5, 1'b0}, 1'b1, `DESC_CR_OFFSET);
    cfg_read("desc_word0_high", 24'h00_0000, 1'b0, {w0[0:31], w0[0:31]});
    cfg_read("desc_word0_low", 24'h00_0001, 1'b0, {w0[32:63], w0[32:63]});
    reg_read("unknown_read", 24'h00_0040, 1'b1, '0, 1'b0, 0);
    cfg_read("desc_past_end", {23'd12, 1'b0}, 1'b1, '0);
    for (int i = 0; i < 4; i++) begin
      reg_write("lcg_write", 24'h00_0030, draw_payload(), 1'b0, 0);
    end

    // Sticky data error, then clear on read
    err_word = '0;
    err_word[62] = 1'b1;
    reg_write("bad_data_parity", 24'h00_0030, draw_payload(), 1'b1, 3);
    reg_read("error_data_set", `ERROR_REG, 1'b0, err_word, 1'b0, 2);
    reg_read("error_data_clear", `ERROR_REG, 1'b0, '0, 1'b0, 0);
    err_word = '0;
    err_word[63] = 1'b1;
    reg_read("bad_addr_parity", 24'h00_0040, 1'b1, '0, 1'b1, 3);
    reg_read("error_addr_set", `ERROR_REG, 1'b0, err_word, 1'b0, 2);
    reg_read("error_addr_clear", `ERROR_REG, 1'b0, '0, 1'b0, 0);

    // Counted job
    req = '0;
    req[`ALGO_START_BIT] = 1'b1;
    req[`ALGO_COUNT_LSB +: 32] = 32'(job_len);
    reg_write("algo_start", `ALGO_REQUEST, req, 1'b0, 1);
    st = '{busy: 1'b1, done: 1'b0, reserved: '0, count: '0};
    reg_read("status_busy", `ALGO_STATUS, 1'b0, st, 1'b0, job_len + 10);
    st = '{busy: 1'b0, done: 1'b1, reserved: '0, count: 32'(job_len)};
    reg_read("status_done", `ALGO_STATUS, 1'b0, st, 1'b0, 0);
    table_len = table_q.size();

    wait (rstn);
    @(posedge clock);
    for (int i = 0; i < table_len; i++) begin
      s = table_q[i];
      @(posedge clock);
      exp = s.keep ? last_data : s.exp_data;
      last_data = exp;
      mmio_in <= '{valid: 1'b1, cfg: s.cfg, read: s.read, doubleword: s.dw,
                   address: s.addr,
                   address_parity: odd_parity_of({40'd0, s.addr}) ^ s.bad_ap,
                   data: s.data, data_parity: odd_parity_of(s.data) ^ s.bad_dp};
      checker_i.push_expect(name_q[i], exp, {s.bad_dp & ~s.read, s.bad_ap});
      for (int k = 0; k < int'(s.gap); k++) begin
        @(posedge clock);
        mmio_in <= '0;
      end
    end
    @(posedge clock);
    mmio_in <= '0;
    while (checker_i.pending_count() != 0) begin
      @(posedge clock);
    end
    repeat (2) @(posedge clock);
    finish_run(checker_i.error_count);
  end

  // Watchdog sized from the table length
  initial begin
    wait (table_len != 0);
    repeat (table_len * (`PIPE_DEPTH + 2) + 200) @(posedge clock);
    $display("** Error: timeout with %0d requests still waiting for an ack",
             checker_i.pending_count());
    finish_run(checker_i.error_count + 1);
  end

endmodule

/* sources.f */
+incdir+.
capi_pkg.sv
mmio.sv
algo_control.sv
afu_top.sv
tb_clock_gen.sv
tb_checker.sv
tb_top.sv

/* Makefile */
# Verilator flow for the AFU MMIO slave

TOP := tb_top

.PHONY: all lint sim clean

all: sim

lint:
	verilator --lint-only --timing --top-module $(TOP) -f sources.f

sim:
	verilator --binary --timing --assert --top-module $(TOP) -Mdir obj_dir -f sources.f
	@out=$$(./obj_dir/V$(TOP)); \
	echo "$$out"; \
	echo "$$out" | grep -qx "Regression passed"

clean:
	rm -rf obj_dir
